//--- common/draw_pkg.sv
// Screen, grid and glyph memory constants, state and opcode enums, block origin tables
package draw_pkg;

    // ==============================
    // Screen and grid geometry
    // ==============================
    localparam int SCREEN_W = 640;
    localparam int SCREEN_H = 480;
    localparam int PANEL_X  = 160;
    localparam int GRID_N   = 9;
    localparam int BLK_SIZE = 52;

    // Field widths
    localparam int COORD_W = 10;
    localparam int BLK_W   = 4;
    localparam int ROW_W   = 6;
    localparam int COL_W   = 6;
    localparam int BANK_W  = 1;
    localparam int INK_W   = 12;

    // Block corners on the mirrored screen, some neighbours are 2 px apart
    localparam logic [COORD_W-1:0] BLK_ORIGIN_X [GRID_N] = '{
        10'd160, 10'd214, 10'd268, 10'd320, 10'd374, 10'd428, 10'd480, 10'd534, 10'd588
    };
    localparam logic [COORD_W-1:0] BLK_ORIGIN_Y [GRID_N] = '{
        10'd0, 10'd54, 10'd108, 10'd160, 10'd214, 10'd268, 10'd320, 10'd374, 10'd428
    };

    // ==============================
    // Glyph timing and banks
    // ==============================
    localparam int IDLE_TICKS = 64;
    localparam int IDLE_W     = $clog2(IDLE_TICKS + 1);
    localparam int NUM_BANKS  = 2;
    localparam int CREDIT_W   = $clog2(NUM_BANKS + 1);

    typedef enum logic [1:0] {
        DRAW_WAIT,
        DRAW_ACTIVE,
        DRAW_FIN
    } draw_state_t;

    typedef enum logic [1:0] {
        OP_SET_PIXEL,
        OP_READ_ROW,
        OP_CLEAR_ROW
    } mem_op_t;

endpackage

//--- mouse_draw/cell_locator.sv
// Mouse coordinate mirroring, grid block lookup and in-block pixel offset
`timescale 1ns/1ps

module cell_locator (
    input  logic [draw_pkg::COORD_W-1:0] mouse_x,
    input  logic [draw_pkg::COORD_W-1:0] mouse_y,
    input  logic [draw_pkg::BLK_W-1:0]   cur_blk_x,
    input  logic [draw_pkg::BLK_W-1:0]   cur_blk_y,
    output logic                         in_panel,
    output logic [draw_pkg::BLK_W-1:0]   blk_x,
    output logic [draw_pkg::BLK_W-1:0]   blk_y,
    output logic [draw_pkg::ROW_W-1:0]   off_row,
    output logic [draw_pkg::COL_W-1:0]   off_col,
    output logic                         in_block
);
    import draw_pkg::*;

    logic [COORD_W-1:0] mx;
    logic [COORD_W-1:0] my;
    logic [COORD_W-1:0] org_x;
    logic [COORD_W-1:0] org_y;
    logic [COORD_W-1:0] dx;
    logic [COORD_W-1:0] dy;

    // Raw (0,0) sits at the bottom right corner
    assign mx = COORD_W'(SCREEN_W - 1) - mouse_x;
    assign my = COORD_W'(SCREEN_H - 1) - mouse_y;

    assign in_panel = (mouse_x < SCREEN_W) && (mouse_y < SCREEN_H) && (mx >= PANEL_X);

    // Last origin not beyond the pointer wins
    always_comb begin
        blk_x = '0;
        blk_y = '0;
        for (int i = 1; i < GRID_N; i++) begin
            if (mx >= BLK_ORIGIN_X[i]) begin
                blk_x = BLK_W'(i);
            end
            if (my >= BLK_ORIGIN_Y[i]) begin
                blk_y = BLK_W'(i);
            end
        end
    end

    // Origin of the block held by capture
    assign org_x = (cur_blk_x < GRID_N) ? BLK_ORIGIN_X[cur_blk_x] : BLK_ORIGIN_X[0];
    assign org_y = (cur_blk_y < GRID_N) ? BLK_ORIGIN_Y[cur_blk_y] : BLK_ORIGIN_Y[0];

    assign dx = mx - org_x;
    assign dy = my - org_y;

    assign off_col  = dx[COL_W-1:0];
    assign off_row  = dy[ROW_W-1:0];
    assign in_block = in_panel && (mx >= org_x) && (my >= org_y)
                      && (dx < BLK_SIZE) && (dy < BLK_SIZE);

endmodule

//--- mouse_draw/stroke_capture.sv
// Stroke FSM with idle timeout, bank credits and pixel write requests
`timescale 1ns/1ps

module stroke_capture (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         mouse_left,
    input  logic                         in_panel,
    input  logic [draw_pkg::BLK_W-1:0]   blk_x,
    input  logic [draw_pkg::BLK_W-1:0]   blk_y,
    input  logic [draw_pkg::ROW_W-1:0]   off_row,
    input  logic [draw_pkg::COL_W-1:0]   off_col,
    input  logic                         in_block,
    output logic [draw_pkg::BLK_W-1:0]   cur_blk_x,
    output logic [draw_pkg::BLK_W-1:0]   cur_blk_y,
    output logic                         req,
    output draw_pkg::mem_op_t            op,
    output logic [draw_pkg::BANK_W-1:0]  bank,
    output logic [draw_pkg::ROW_W-1:0]   row,
    output logic [draw_pkg::COL_W-1:0]   col,
    input  logic                         gnt,
    output logic                         glyph_valid,
    output logic [draw_pkg::BANK_W-1:0]  glyph_bank,
    output logic [draw_pkg::BLK_W-1:0]   glyph_blk_x,
    output logic [draw_pkg::BLK_W-1:0]   glyph_blk_y,
    input  logic                         credit_return
);
    import draw_pkg::*;

    draw_state_t         state;
    logic [IDLE_W-1:0]   idle_cnt;
    logic [CREDIT_W-1:0] credits;
    logic                req_free;

    // A new sample may load once the previous one is granted
    assign req_free = !req || gnt;

    // ==============================
    // Stroke FSM
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= DRAW_WAIT;
            idle_cnt  <= '0;
            credits   <= CREDIT_W'(NUM_BANKS);
            bank      <= '0;
            cur_blk_x <= '0;
            cur_blk_y <= '0;
        end else begin
            credits <= credits + CREDIT_W'(credit_return) - CREDIT_W'(glyph_valid);
            case (state)
                DRAW_WAIT: begin
                    if (mouse_left && in_panel && (credits != '0)) begin
                        cur_blk_x <= blk_x;
                        cur_blk_y <= blk_y;
                        idle_cnt  <= '0;
                        state     <= DRAW_ACTIVE;
                    end
                end
                DRAW_ACTIVE: begin
                    if (idle_cnt == IDLE_W'(IDLE_TICKS)) begin
                        state <= DRAW_FIN;
                    end else if (mouse_left) begin
                        idle_cnt <= '0;
                    end else begin
                        idle_cnt <= idle_cnt + 1'b1;
                    end
                end
                DRAW_FIN: begin
                    // Wait for the last pixel write to drain
                    if (glyph_valid) begin
                        bank  <= ~bank;
                        state <= DRAW_WAIT;
                    end
                end
                default: state <= DRAW_WAIT;
            endcase
        end
    end

    // ==============================
    // Pixel sample and request
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            req <= 1'b0;
        end else if (req_free) begin
            req <= (state == DRAW_ACTIVE) && mouse_left && in_block;
        end
    end

    // Samples seen while a request waits are dropped
    always_ff @(posedge clk) begin
        if (req_free) begin
            row <= off_row;
            col <= off_col;
        end
    end

    assign op = OP_SET_PIXEL;

    assign glyph_valid = (state == DRAW_FIN) && !req;
    assign glyph_bank  = bank;
    assign glyph_blk_x = cur_blk_x;
    assign glyph_blk_y = cur_blk_y;

endmodule

//--- hw/ram_arbiter.sv
// Two-way round-robin arbiter of capture and analyzer onto the glyph memory port
`timescale 1ns/1ps

module ram_arbiter (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         cap_req,
    input  draw_pkg::mem_op_t            cap_op,
    input  logic [draw_pkg::BANK_W-1:0]  cap_bank,
    input  logic [draw_pkg::ROW_W-1:0]   cap_row,
    input  logic [draw_pkg::COL_W-1:0]   cap_col,
    output logic                         cap_gnt,
    input  logic                         ana_req,
    input  draw_pkg::mem_op_t            ana_op,
    input  logic [draw_pkg::BANK_W-1:0]  ana_bank,
    input  logic [draw_pkg::ROW_W-1:0]   ana_row,
    output logic                         ana_gnt,
    output logic                         mem_en,
    output draw_pkg::mem_op_t            mem_op,
    output logic [draw_pkg::BANK_W-1:0]  mem_bank,
    output logic [draw_pkg::ROW_W-1:0]   mem_row,
    output logic [draw_pkg::COL_W-1:0]   mem_col
);
    // Set when capture won the last contested or uncontested grant
    logic last_cap;

    // Capture loses only a tie right after its own win
    assign cap_gnt = cap_req && (!ana_req || !last_cap);
    assign ana_gnt = ana_req && !cap_gnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_cap <= 1'b0;
        end else if (cap_gnt) begin
            last_cap <= 1'b1;
        end else if (ana_gnt) begin
            last_cap <= 1'b0;
        end
    end

    // ==============================
    // Winner mux
    // ==============================
    assign mem_en   = cap_gnt || ana_gnt;
    assign mem_op   = cap_gnt ? cap_op : ana_op;
    assign mem_bank = cap_gnt ? cap_bank : ana_bank;
    assign mem_row  = cap_gnt ? cap_row : ana_row;
    // Analyzer works on whole rows
    assign mem_col  = cap_gnt ? cap_col : '0;

endmodule

//--- hw/glyph_ram.sv
// Two-bank glyph bitmap memory with set-pixel, read-row and clear-row
`timescale 1ns/1ps

module glyph_ram (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          mem_en,
    input  draw_pkg::mem_op_t             mem_op,
    input  logic [draw_pkg::BANK_W-1:0]   mem_bank,
    input  logic [draw_pkg::ROW_W-1:0]    mem_row,
    input  logic [draw_pkg::COL_W-1:0]    mem_col,
    output logic [draw_pkg::BLK_SIZE-1:0] rd_row
);
    import draw_pkg::*;

    logic [BLK_SIZE-1:0] mem [NUM_BANKS][BLK_SIZE];

    always_ff @(posedge clk) begin
        if (rst) begin
            // Both banks start empty
            for (int b = 0; b < NUM_BANKS; b++) begin
                for (int r = 0; r < BLK_SIZE; r++) begin
                    mem[b][r] <= '0;
                end
            end
        end else if (mem_en) begin
            case (mem_op)
                OP_SET_PIXEL: mem[mem_bank][mem_row][mem_col] <= 1'b1;
                OP_READ_ROW:  rd_row <= mem[mem_bank][mem_row];
                OP_CLEAR_ROW: mem[mem_bank][mem_row] <= '0;
                default: ;
            endcase
        end
    end

endmodule

//--- hw/glyph_analyzer.sv
// Glyph queue, row scan with ink count and bounding box, bank clear and credit return
`timescale 1ns/1ps

module glyph_analyzer (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          glyph_valid,
    input  logic [draw_pkg::BANK_W-1:0]   glyph_bank,
    input  logic [draw_pkg::BLK_W-1:0]    glyph_blk_x,
    input  logic [draw_pkg::BLK_W-1:0]    glyph_blk_y,
    output logic                          req,
    output draw_pkg::mem_op_t             op,
    output logic [draw_pkg::BANK_W-1:0]   bank,
    output logic [draw_pkg::ROW_W-1:0]    row,
    input  logic                          gnt,
    input  logic [draw_pkg::BLK_SIZE-1:0] rd_row,
    output logic                          credit_return,
    output logic                          result_valid,
    output logic [draw_pkg::BLK_W-1:0]    result_blk_x,
    output logic [draw_pkg::BLK_W-1:0]    result_blk_y,
    output logic [draw_pkg::INK_W-1:0]    result_ink,
    output logic [draw_pkg::ROW_W-1:0]    result_row_min,
    output logic [draw_pkg::ROW_W-1:0]    result_row_max,
    output logic [draw_pkg::COL_W-1:0]    result_col_min,
    output logic [draw_pkg::COL_W-1:0]    result_col_max
);
    import draw_pkg::*;

    localparam int PTR_W = $clog2(NUM_BANKS);

    // Finished glyph queue, one slot per bank
    logic [BANK_W-1:0]   q_bank [NUM_BANKS];
    logic [BLK_W-1:0]    q_bx   [NUM_BANKS];
    logic [BLK_W-1:0]    q_by   [NUM_BANKS];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CREDIT_W-1:0] q_cnt;

    logic              active;
    logic              clr;
    logic              rd_wait;
    logic              done;
    logic [ROW_W-1:0]  row_idx;

    logic [COL_W-1:0]  row_pop;
    logic [COL_W-1:0]  row_lo;
    logic [COL_W-1:0]  row_hi;

    // ==============================
    // Queue
    // ==============================
    always_ff @(posedge clk) begin
        if (glyph_valid) begin
            q_bank[wr_ptr] <= glyph_bank;
            q_bx[wr_ptr]   <= glyph_blk_x;
            q_by[wr_ptr]   <= glyph_blk_y;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            q_cnt  <= '0;
        end else begin
            if (glyph_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (done) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            q_cnt <= q_cnt + CREDIT_W'(glyph_valid) - CREDIT_W'(done);
        end
    end

    // ==============================
    // Row scan, read then clear
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            active  <= 1'b0;
            clr     <= 1'b0;
            rd_wait <= 1'b0;
            done    <= 1'b0;
            row_idx <= '0;
        end else begin
            done    <= 1'b0;
            rd_wait <= gnt && !clr;
            if (!active && !done && (q_cnt != '0)) begin
                active  <= 1'b1;
                clr     <= 1'b0;
                row_idx <= '0;
            end else if (active && gnt) begin
                clr <= !clr;
                if (clr && (row_idx == ROW_W'(BLK_SIZE - 1))) begin
                    active <= 1'b0;
                    done   <= 1'b1;
                end else if (clr) begin
                    row_idx <= row_idx + 1'b1;
                end
            end
        end
    end

    // Population and column extent of the returned row
    always_comb begin
        row_pop = '0;
        row_lo  = '1;
        row_hi  = '0;
        for (int i = 0; i < BLK_SIZE; i++) begin
            if (rd_row[i]) begin
                row_pop = row_pop + 1'b1;
                row_hi  = COL_W'(i);
                if (row_lo == '1) begin
                    row_lo = COL_W'(i);
                end
            end
        end
    end

    // Accumulators start fresh with each glyph
    always_ff @(posedge clk) begin
        if (!active && !done && (q_cnt != '0)) begin
            result_ink     <= '0;
            result_row_min <= '1;
            result_row_max <= '0;
            result_col_min <= '1;
            result_col_max <= '0;
        end else if (rd_wait && (row_pop != '0)) begin
            result_ink <= result_ink + INK_W'(row_pop);
            if (row_idx < result_row_min) begin
                result_row_min <= row_idx;
            end
            if (row_idx > result_row_max) begin
                result_row_max <= row_idx;
            end
            if (row_lo < result_col_min) begin
                result_col_min <= row_lo;
            end
            if (row_hi > result_col_max) begin
                result_col_max <= row_hi;
            end
        end
    end

    assign req  = active;
    assign op   = clr ? OP_CLEAR_ROW : OP_READ_ROW;
    assign bank = q_bank[rd_ptr];
    assign row  = row_idx;

    // Head entry stays in the queue until its result pulse
    assign result_valid  = done;
    assign credit_return = done;
    assign result_blk_x  = q_bx[rd_ptr];
    assign result_blk_y  = q_by[rd_ptr];

endmodule

//--- hw/draw_top.sv
// Top level of locator, stroke capture, memory arbiter, glyph memory and analyzer
`timescale 1ns/1ps

module draw_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [draw_pkg::COORD_W-1:0] mouse_x,
    input  logic [draw_pkg::COORD_W-1:0] mouse_y,
    input  logic                         mouse_left,
    output logic                         result_valid,
    output logic [draw_pkg::BLK_W-1:0]   result_blk_x,
    output logic [draw_pkg::BLK_W-1:0]   result_blk_y,
    output logic [draw_pkg::INK_W-1:0]   result_ink,
    output logic [draw_pkg::ROW_W-1:0]   result_row_min,
    output logic [draw_pkg::ROW_W-1:0]   result_row_max,
    output logic [draw_pkg::COL_W-1:0]   result_col_min,
    output logic [draw_pkg::COL_W-1:0]   result_col_max
);
    import draw_pkg::*;

    // Locator and capture
    logic              in_panel;
    logic              in_block;
    logic [BLK_W-1:0]  blk_x;
    logic [BLK_W-1:0]  blk_y;
    logic [BLK_W-1:0]  cur_blk_x;
    logic [BLK_W-1:0]  cur_blk_y;
    logic [ROW_W-1:0]  off_row;
    logic [COL_W-1:0]  off_col;

    // Capture port
    logic              cap_req;
    logic              cap_gnt;
    mem_op_t           cap_op;
    logic [BANK_W-1:0] cap_bank;
    logic [ROW_W-1:0]  cap_row;
    logic [COL_W-1:0]  cap_col;

    // Analyzer port
    logic              ana_req;
    logic              ana_gnt;
    mem_op_t           ana_op;
    logic [BANK_W-1:0] ana_bank;
    logic [ROW_W-1:0]  ana_row;

    // Memory side
    logic                mem_en;
    mem_op_t             mem_op;
    logic [BANK_W-1:0]   mem_bank;
    logic [ROW_W-1:0]    mem_row;
    logic [COL_W-1:0]    mem_col;
    logic [BLK_SIZE-1:0] rd_row;

    // Glyph hand-off and credits
    logic              glyph_valid;
    logic [BANK_W-1:0] glyph_bank;
    logic [BLK_W-1:0]  glyph_blk_x;
    logic [BLK_W-1:0]  glyph_blk_y;
    logic              credit_return;

    cell_locator u_cell_locator (
        .mouse_x   (mouse_x),
        .mouse_y   (mouse_y),
        .cur_blk_x (cur_blk_x),
        .cur_blk_y (cur_blk_y),
        .in_panel  (in_panel),
        .blk_x     (blk_x),
        .blk_y     (blk_y),
        .off_row   (off_row),
        .off_col   (off_col),
        .in_block  (in_block)
    );

    stroke_capture u_stroke_capture (
        .clk           (clk),
        .rst           (rst),
        .mouse_left    (mouse_left),
        .in_panel      (in_panel),
        .blk_x         (blk_x),
        .blk_y         (blk_y),
        .off_row       (off_row),
        .off_col       (off_col),
        .in_block      (in_block),
        .cur_blk_x     (cur_blk_x),
        .cur_blk_y     (cur_blk_y),
        .req           (cap_req),
        .op            (cap_op),
        .bank          (cap_bank),
        .row           (cap_row),
        .col           (cap_col),
        .gnt           (cap_gnt),
        .glyph_valid   (glyph_valid),
        .glyph_bank    (glyph_bank),
        .glyph_blk_x   (glyph_blk_x),
        .glyph_blk_y   (glyph_blk_y),
        .credit_return (credit_return)
    );

    ram_arbiter u_ram_arbiter (
        .clk      (clk),
        .rst      (rst),
        .cap_req  (cap_req),
        .cap_op   (cap_op),
        .cap_bank (cap_bank),
        .cap_row  (cap_row),
        .cap_col  (cap_col),
        .cap_gnt  (cap_gnt),
        .ana_req  (ana_req),
        .ana_op   (ana_op),
        .ana_bank (ana_bank),
        .ana_row  (ana_row),
        .ana_gnt  (ana_gnt),
        .mem_en   (mem_en),
        .mem_op   (mem_op),
        .mem_bank (mem_bank),
        .mem_row  (mem_row),
        .mem_col  (mem_col)
    );

    glyph_ram u_glyph_ram (
        .clk      (clk),
        .rst      (rst),
        .mem_en   (mem_en),
        .mem_op   (mem_op),
        .mem_bank (mem_bank),
        .mem_row  (mem_row),
        .mem_col  (mem_col),
        .rd_row   (rd_row)
    );

    glyph_analyzer u_glyph_analyzer (
        .clk            (clk),
        .rst            (rst),
        .glyph_valid    (glyph_valid),
        .glyph_bank     (glyph_bank),
        .glyph_blk_x    (glyph_blk_x),
        .glyph_blk_y    (glyph_blk_y),
        .req            (ana_req),
        .op             (ana_op),
        .bank           (ana_bank),
        .row            (ana_row),
        .gnt            (ana_gnt),
        .rd_row         (rd_row),
        .credit_return  (credit_return),
        .result_valid   (result_valid),
        .result_blk_x   (result_blk_x),
        .result_blk_y   (result_blk_y),
        .result_ink     (result_ink),
        .result_row_min (result_row_min),
        .result_row_max (result_row_max),
        .result_col_min (result_col_min),
        .result_col_max (result_col_max)
    );

endmodule

//--- bench/draw_tb.sv
// Testbench for the drawing top level with a bitmap reference model and result checks
`timescale 1ns/1ps

module draw_tb;
    import draw_pkg::*;

    localparam int TIMEOUT_CYCLES = 5000;

    logic               clk;
    logic               rst;
    logic [COORD_W-1:0] mouse_x;
    logic [COORD_W-1:0] mouse_y;
    logic               mouse_left;
    logic               result_valid;
    logic [BLK_W-1:0]   result_blk_x;
    logic [BLK_W-1:0]   result_blk_y;
    logic [INK_W-1:0]   result_ink;
    logic [ROW_W-1:0]   result_row_min;
    logic [ROW_W-1:0]   result_row_max;
    logic [COL_W-1:0]   result_col_min;
    logic [COL_W-1:0]   result_col_max;

    // Reference bitmap of the glyph being drawn
    logic [BLK_SIZE-1:0] model_rows [BLK_SIZE];

    // Expected results in draw order
    int exp_bx_q[$];
    int exp_by_q[$];
    int exp_ink_q[$];
    int exp_rmin_q[$];
    int exp_rmax_q[$];
    int exp_cmin_q[$];
    int exp_cmax_q[$];
    int bx;
    int by;

    draw_top u_draw_top (
        .clk            (clk),
        .rst            (rst),
        .mouse_x        (mouse_x),
        .mouse_y        (mouse_y),
        .mouse_left     (mouse_left),
        .result_valid   (result_valid),
        .result_blk_x   (result_blk_x),
        .result_blk_y   (result_blk_y),
        .result_ink     (result_ink),
        .result_row_min (result_row_min),
        .result_row_max (result_row_max),
        .result_col_min (result_col_min),
        .result_col_max (result_col_max)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_error_and_stop(string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_field(string name, int expected, int actual);
        assert (expected == actual) else begin
            report_error_and_stop($sformatf("Fail at %0t: %s expected %0d, actual %0d",
                $time, name, expected, actual));
        end
    endtask

    // ==============================
    // Stimulus and reference model
    // ==============================
    // Drives screen coordinates as mirrored raw coordinates
    task automatic drive_mouse(int sx, int sy, logic left);
        @(posedge clk);
        mouse_x    <= COORD_W'(SCREEN_W - 1 - sx);
        mouse_y    <= COORD_W'(SCREEN_H - 1 - sy);
        mouse_left <= left;
    endtask

    task automatic clear_model();
        for (int r = 0; r < BLK_SIZE; r++) begin
            model_rows[r] = '0;
        end
    endtask

    task automatic hold_point(int sx, int sy, int blk_x, int blk_y);
        int ox;
        int oy;
        ox = int'(BLK_ORIGIN_X[blk_x]);
        oy = int'(BLK_ORIGIN_Y[blk_y]);
        drive_mouse(sx, sy, 1'b1);
        repeat (3) @(posedge clk);
        // Only points inside the held block leave ink
        if (sx >= ox && sx < ox + BLK_SIZE && sy >= oy && sy < oy + BLK_SIZE) begin
            model_rows[sy - oy][sx - ox] = 1'b1;
        end
    endtask

    task automatic stroke(int blk_x, int blk_y, int npts);
        int sx;
        int sy;
        int nbx;
        nbx = (blk_x + 1) % GRID_N;
        for (int i = 0; i < npts; i++) begin
            if (i % 5 == 4) begin
                // Dragged into the neighbouring block
                sx = int'(BLK_ORIGIN_X[nbx]) + int'($urandom % BLK_SIZE);
            end else begin
                sx = int'(BLK_ORIGIN_X[blk_x]) + int'($urandom % BLK_SIZE);
            end
            sy = int'(BLK_ORIGIN_Y[blk_y]) + int'($urandom % BLK_SIZE);
            hold_point(sx, sy, blk_x, blk_y);
        end
    endtask

    task automatic push_expected(int blk_x, int blk_y);
        int ink;
        int rmin;
        int rmax;
        int cmin;
        int cmax;
        ink  = 0;
        rmin = 63;
        rmax = 0;
        cmin = 63;
        cmax = 0;
        for (int r = 0; r < BLK_SIZE; r++) begin
            for (int c = 0; c < BLK_SIZE; c++) begin
                if (model_rows[r][c]) begin
                    ink++;
                    rmin = (r < rmin) ? r : rmin;
                    rmax = (r > rmax) ? r : rmax;
                    cmin = (c < cmin) ? c : cmin;
                    cmax = (c > cmax) ? c : cmax;
                end
            end
        end
        exp_bx_q.push_back(blk_x);
        exp_by_q.push_back(blk_y);
        exp_ink_q.push_back(ink);
        exp_rmin_q.push_back(rmin);
        exp_rmax_q.push_back(rmax);
        exp_cmin_q.push_back(cmin);
        exp_cmax_q.push_back(cmax);
    endtask

    task automatic release_for(int cycles);
        @(posedge clk);
        mouse_left <= 1'b0;
        repeat (cycles) @(posedge clk);
    endtask

    // Glyph ends IDLE_TICKS+1 cycles after the release
    task automatic finish_glyph(int blk_x, int blk_y);
        push_expected(blk_x, blk_y);
        release_for(IDLE_TICKS + 8);
    endtask

    // A bank is free once fewer glyphs than banks are outstanding
    task automatic wait_for_credit();
        int n;
        n = 0;
        while (exp_ink_q.size() >= NUM_BANKS && n < TIMEOUT_CYCLES) begin
            @(posedge clk);
            n++;
        end
        if (exp_ink_q.size() >= NUM_BANKS) begin
            report_error_and_stop("Timeout while waiting for a bank credit to come back");
        end
    endtask

    task automatic wait_for_results();
        int n;
        n = 0;
        while (exp_ink_q.size() != 0 && n < TIMEOUT_CYCLES) begin
            @(posedge clk);
            n++;
        end
        if (exp_ink_q.size() != 0) begin
            report_error_and_stop("Timeout while waiting for result_valid of a drawn glyph");
        end
    endtask

    // ==============================
    // Result monitor
    // ==============================
    always @(posedge clk) begin
        if (!rst && result_valid) begin
            assert (exp_ink_q.size() != 0) begin
                check_field("result_blk_x", exp_bx_q[0], int'(result_blk_x));
                check_field("result_blk_y", exp_by_q[0], int'(result_blk_y));
                check_field("result_ink", exp_ink_q[0], int'(result_ink));
                check_field("result_row_min", exp_rmin_q[0], int'(result_row_min));
                check_field("result_row_max", exp_rmax_q[0], int'(result_row_max));
                check_field("result_col_min", exp_cmin_q[0], int'(result_col_min));
                check_field("result_col_max", exp_cmax_q[0], int'(result_col_max));
                void'(exp_bx_q.pop_front());
                void'(exp_by_q.pop_front());
                void'(exp_ink_q.pop_front());
                void'(exp_rmin_q.pop_front());
                void'(exp_rmax_q.pop_front());
                void'(exp_cmin_q.pop_front());
                void'(exp_cmax_q.pop_front());
            end else begin
                report_error_and_stop("result_valid pulsed with no finished glyph outstanding");
            end
        end
    end

    initial begin
        void'($urandom(32'hab22));
        rst        = 1'b1;
        mouse_x    = '0;
        mouse_y    = '0;
        mouse_left = 1'b0;
        clear_model();
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // Idle input leaves result_valid low
        repeat (200) @(posedge clk);

        // Press left of the panel starts nothing
        drive_mouse(100, 240, 1'b1);
        repeat (5) @(posedge clk);
        release_for(IDLE_TICKS + TIMEOUT_CYCLES);

        // One random stroke with some points outside the block
        bx = int'($urandom % GRID_N);
        by = int'($urandom % GRID_N);
        clear_model();
        stroke(bx, by, 20);
        finish_glyph(bx, by);
        wait_for_results();

        // A short release continues the same glyph
        bx = int'($urandom % GRID_N);
        by = int'($urandom % GRID_N);
        wait_for_credit();
        clear_model();
        stroke(bx, by, 10);
        release_for(20);
        stroke(bx, by, 10);
        finish_glyph(bx, by);
        wait_for_results();

        // Back to back glyphs overlap with analysis
        for (int g = 0; g < 3; g++) begin
            bx = int'($urandom % GRID_N);
            by = int'($urandom % GRID_N);
            wait_for_credit();
            clear_model();
            stroke(bx, by, 20);
            finish_glyph(bx, by);
        end
        wait_for_results();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- draw.f
common/draw_pkg.sv
mouse_draw/cell_locator.sv
mouse_draw/stroke_capture.sv
hw/ram_arbiter.sv
hw/glyph_ram.sv
hw/glyph_analyzer.sv
hw/draw_top.sv
bench/draw_tb.sv

//--- Makefile
SRCS := $(shell grep -v '^+' draw.f)

all: run

obj_dir/Vdraw_tb: draw.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f draw.f --top-module draw_tb -o Vdraw_tb

run: obj_dir/Vdraw_tb
	@out="$$(./obj_dir/Vdraw_tb)"; echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

.PHONY: all run clean
